// ==== rtl/bpu_pkg.sv ====
package bpu_pkg;

    // datapath width
    localparam int XLEN = 32;

    // bimodal direction table, indexed by pc[9:1]
    localparam int BHT_ENTRIES = 512;
    localparam int BHT_IDX_W   = 9;

    // branch target buffer, index pc[9:2], tag pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_TAG_W   = 22;

    // return address stack, pointer holds 0..RAS_DEPTH
    localparam int RAS_DEPTH = 32;
    localparam int RAS_PTR_W = 6;

    localparam logic [1:0] CTR_INIT = 2'b01;   // weakly not-taken

    // rv32 major opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JAL,
        CF_JALR
    } cf_op_e;

    typedef struct packed {
        cf_op_e            op;
        logic              is_ret;
        logic [XLEN-1:0]   b_imm;   // sign-extended
        logic [XLEN-1:0]   j_imm;   // sign-extended
    } decode_s;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic            taken;
        logic [XLEN-1:0] target;
    } resolve_s;

    typedef struct packed {
        logic            is_cf;
        logic            taken;
        logic [XLEN-1:0] target;
    } pred_s;

endpackage

// ==== rtl/cf_decode.sv ====
`timescale 1ns/1ns

module cf_decode import bpu_pkg::*; (
    input  logic [XLEN-1:0] inst_i,
    output decode_s         dec_o
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] i_imm;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign i_imm  = inst_i[31:20];

    always_comb begin
        case (opcode)
            OPC_BRANCH: dec_o.op = CF_BRANCH;
            OPC_JAL:    dec_o.op = CF_JAL;
            OPC_JALR:   dec_o.op = CF_JALR;
            default:    dec_o.op = CF_NONE;
        endcase

        // return: jalr x0, 0(ra) or jalr x0, 0(t0)
        dec_o.is_ret = (opcode == OPC_JALR) && (rd == 5'd0) &&
                       ((rs1 == 5'd1) || (rs1 == 5'd5)) && (i_imm == 12'd0);

        // b-type offset
        dec_o.b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};

        // j-type offset
        dec_o.j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};
    end

endmodule

// ==== rtl/bimodal_table.sv ====
`timescale 1ns/1ns

module bimodal_table import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] rd_pc_i,
    output logic            rd_taken_o,
    input  logic            train_valid_i,
    input  logic [XLEN-1:0] train_pc_i,
    input  logic            train_taken_i
);

    logic [1:0] ctr [BHT_ENTRIES];

    logic [BHT_IDX_W-1:0] rd_idx;
    logic [BHT_IDX_W-1:0] train_idx;
    logic [1:0]           train_ctr;

    // halfword granular index, pc[9:1]
    assign rd_idx    = rd_pc_i[BHT_IDX_W:1];
    assign train_idx = train_pc_i[BHT_IDX_W:1];
    assign train_ctr = ctr[train_idx];

    assign rd_taken_o = ctr[rd_idx][1];   // msb gives direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr[i] <= CTR_INIT;
            end
        end else if (train_valid_i) begin
            if (train_taken_i) begin
                if (train_ctr != 2'b11) begin
                    ctr[train_idx] <= train_ctr + 2'b01;
                end
            end else begin
                if (train_ctr != 2'b00) begin
                    ctr[train_idx] <= train_ctr - 2'b01;
                end
            end
        end
    end

    // EX must hand over a clean pc and outcome with every resolve
    a_train_known: assert property (
        @(posedge clk) disable iff (rst)
        train_valid_i |-> !$isunknown({train_pc_i, train_taken_i})
    ) else $error("bimodal train with unknown pc or outcome");

endmodule

// ==== rtl/btb.sv ====
`timescale 1ns/1ns

module btb import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] lookup_pc_i,
    output logic            hit_o,
    output logic [XLEN-1:0] target_o,
    input  logic            fill_i,
    input  logic [XLEN-1:0] fill_pc_i,
    input  logic [XLEN-1:0] fill_target_i
);

    logic [BTB_TAG_W-1:0] tag_mem    [BTB_ENTRIES];
    logic [XLEN-1:0]      target_mem [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid;

    logic [BTB_IDX_W-1:0] lookup_idx;
    logic [BTB_TAG_W-1:0] lookup_tag;
    logic [BTB_IDX_W-1:0] fill_idx;
    logic [BTB_TAG_W-1:0] fill_tag;

    // word index pc[9:2], tag is everything above
    assign lookup_idx = lookup_pc_i[BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc_i[XLEN-1:XLEN-BTB_TAG_W];
    assign fill_idx   = fill_pc_i[BTB_IDX_W+1:2];
    assign fill_tag   = fill_pc_i[XLEN-1:XLEN-BTB_TAG_W];

    assign hit_o    = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign target_o = target_mem[lookup_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_i) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    // tag and target written on every fill
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[fill_idx]    <= fill_tag;
            target_mem[fill_idx] <= fill_target_i;   // overwrite on conflict
        end
    end

endmodule

// ==== rtl/ras.sv ====
`timescale 1ns/1ns

module ras import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            push_i,
    input  logic [XLEN-1:0] push_addr_i,
    input  logic            pop_i,
    output logic [XLEN-1:0] top_o,
    output logic            empty_o
);

    logic [XLEN-1:0] stack [RAS_DEPTH];

    logic [RAS_PTR_W-1:0] ptr;       // next free slot, also the count
    logic [RAS_PTR_W-2:0] wr_idx;
    logic [RAS_PTR_W-2:0] top_idx;
    logic                 full;
    logic                 do_pop;
    logic                 do_push;

    assign wr_idx  = ptr[RAS_PTR_W-2:0];
    assign top_idx = wr_idx - (RAS_PTR_W-1)'(1);   // wraps when empty, masked by empty_o

    assign empty_o = (ptr == '0);
    assign full    = (ptr == RAS_PTR_W'(RAS_DEPTH));

    assign top_o = stack[top_idx];

    // pop on empty dropped, push on full dropped unless a pop frees the slot
    assign do_pop  = pop_i && !empty_o;
    assign do_push = push_i && (!full || do_pop);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (do_push && !do_pop) begin
            ptr <= ptr + RAS_PTR_W'(1);
        end else if (do_pop && !do_push) begin
            ptr <= ptr - RAS_PTR_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && do_pop) begin
            stack[top_idx] <= push_addr_i;   // replace top in place
        end else if (do_push) begin
            stack[wr_idx] <= push_addr_i;
        end
    end

    // count can reach the depth but never pass it
    a_ptr_bound: assert property (
        @(posedge clk) disable iff (rst)
        ptr <= RAS_PTR_W'(RAS_DEPTH)
    ) else $error("ras pointer past depth: %0d", ptr);

endmodule

// ==== rtl/bpu_top.sv ====
`timescale 1ns/1ns

module bpu_top import bpu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] fetch_pc_i,
    input  logic [XLEN-1:0] fetch_inst_i,
    output pred_s           pred_o,
    input  logic            resolve_valid_i,
    input  resolve_s        resolve_i,
    input  logic            ras_push_valid_i,
    input  logic [XLEN-1:0] ras_push_addr_i,
    input  logic            stall_i
);

    decode_s         fetch_dec;
    decode_s         res_dec;
    logic            bht_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] ras_top;
    logic            ras_empty;
    logic            ras_push;
    logic            ras_pop;
    logic            btb_fill;
    logic [XLEN-1:0] pc_plus4;

    cf_decode u_fetch_dec (
        .inst_i (fetch_inst_i),
        .dec_o  (fetch_dec)
    );

    // only the return flag is needed on the resolve side
    cf_decode u_res_dec (
        .inst_i (resolve_i.inst),
        .dec_o  (res_dec)
    );

    assign ras_push = ras_push_valid_i && !stall_i;
    assign ras_pop  = resolve_valid_i && resolve_i.taken && res_dec.is_ret;
    assign btb_fill = resolve_valid_i && resolve_i.taken;

    bimodal_table u_bht (
        .clk           (clk),
        .rst           (rst),
        .rd_pc_i       (fetch_pc_i),
        .rd_taken_o    (bht_taken),
        .train_valid_i (resolve_valid_i),   // every resolve trains
        .train_pc_i    (resolve_i.pc),
        .train_taken_i (resolve_i.taken)
    );

    btb u_btb (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc_i   (fetch_pc_i),
        .hit_o         (btb_hit),
        .target_o      (btb_target),
        .fill_i        (btb_fill),
        .fill_pc_i     (resolve_i.pc),
        .fill_target_i (resolve_i.target)
    );

    ras u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_addr_i (ras_push_addr_i),
        .pop_i       (ras_pop),
        .top_o       (ras_top),
        .empty_o     (ras_empty)
    );

    assign pc_plus4 = fetch_pc_i + XLEN'(4);

    always_comb begin
        pred_o.is_cf  = 1'b0;
        pred_o.taken  = 1'b0;
        pred_o.target = pc_plus4;   // fall through by default

        case (fetch_dec.op)
            CF_BRANCH: begin
                pred_o.is_cf = 1'b1;
                pred_o.taken = bht_taken;
                if (bht_taken) begin
                    pred_o.target = btb_hit ? btb_target : fetch_pc_i + fetch_dec.b_imm;
                end
            end
            CF_JAL: begin
                pred_o.is_cf  = 1'b1;
                pred_o.taken  = 1'b1;
                pred_o.target = btb_hit ? btb_target : fetch_pc_i + fetch_dec.j_imm;
            end
            CF_JALR: begin
                pred_o.is_cf = 1'b1;
                if (fetch_dec.is_ret) begin
                    // empty stack falls back to not taken
                    if (!ras_empty) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = ras_top;
                    end
                end else begin
                    pred_o.taken = bht_taken;
                    if (bht_taken && btb_hit) begin
                        pred_o.target = btb_target;   // no static target for jalr
                    end
                end
            end
            default: begin
                pred_o.is_cf = 1'b0;
            end
        endcase
    end

endmodule

// ==== sim/tb_bpu.sv ====
`timescale 1ns/1ns

module tb_bpu import bpu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY = 5;
    localparam int SETTLE_DLY = 20;
    localparam int RESET_CYCLES = 16;
    localparam int unsigned SEED = 32'h63c8d6d3;
    localparam int TEST_CYCLES = 2 + 10 + 6 + 12 + 40 + 10;   // per test, with slack
    localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + TEST_CYCLES + 50;
    localparam logic [12:0] B_OFF = 13'h0100;          // +256
    localparam logic [20:0] J_OFF = 21'h1F_F800;       // -2048
    localparam logic [XLEN-1:0] RET_INST = {12'd0, 5'd1, 3'b000, 5'd0, 7'b1100111};
    localparam logic [XLEN-1:0] ADDI_INST = {12'd5, 5'd1, 3'b000, 5'd1, 7'b0010011};

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] fetch_inst;
    pred_s           pred;
    logic            resolve_valid;
    resolve_s        resolve;
    logic            ras_push_valid;
    logic [XLEN-1:0] ras_push_addr;
    logic            stall;

    string cur_test;
    int    checks = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_checks;
    int    test_errors;

    bpu_top uut (
        .clk              (clk),
        .rst              (rst),
        .fetch_pc_i       (fetch_pc),
        .fetch_inst_i     (fetch_inst),
        .pred_o           (pred),
        .resolve_valid_i  (resolve_valid),
        .resolve_i        (resolve),
        .ras_push_valid_i (ras_push_valid),
        .ras_push_addr_i  (ras_push_addr),
        .stall_i          (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // beq x1, x2, off
    function automatic logic [XLEN-1:0] branch_inst(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    // jal x1, off
    function automatic logic [XLEN-1:0] jal_inst(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // random upper bits, chosen btb index so tests keep apart
    function automatic logic [XLEN-1:0] rand_pc(input logic [7:0] idx);
        logic [XLEN-1:0] r;
        r = $urandom();
        return {r[31:10], idx, 2'b00};
    endfunction

    function automatic logic [XLEN-1:0] rand_addr();
        logic [XLEN-1:0] r;
        r = $urandom();
        return {r[31:2], 2'b00};
    endfunction

    function automatic string pred_to_str(input pred_s p);
        return $sformatf("cf=%0b taken=%0b target=%08h", p.is_cf, p.taken, p.target);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    endtask

    task automatic set_fetch(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst);
        fetch_pc = pc;
        fetch_inst = inst;
    endtask

    // compare the combinational prediction once the fetch inputs have settled
    task automatic check_pred(input logic cf, input logic tkn, input logic [XLEN-1:0] tgt);
        pred_s want;
        want.is_cf = cf;
        want.taken = tkn;
        want.target = tgt;
        #SETTLE_DLY;
        checks++;
        test_checks++;
        if (pred !== want) begin
            errors++;
            test_errors++;
            $display("** Error %s: expected %s, actual %s",
                     cur_test, pred_to_str(want), pred_to_str(pred));
        end
        next_cycle();
    endtask

    task automatic resolve_one(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst,
                               input logic tkn, input logic [XLEN-1:0] tgt);
        resolve_valid = 1'b1;
        resolve.pc = pc;
        resolve.inst = inst;
        resolve.taken = tkn;
        resolve.target = tgt;
        next_cycle();
        resolve_valid = 1'b0;
        resolve = '0;
    endtask

    task automatic push_one(input logic [XLEN-1:0] addr, input logic stl);
        ras_push_valid = 1'b1;
        ras_push_addr = addr;
        stall = stl;
        next_cycle();
        ras_push_valid = 1'b0;
        stall = 1'b0;
    endtask

    task automatic test_non_cf();
        logic [XLEN-1:0] pc;
        begin_test("non_cf");
        pc = rand_pc(8'h08);
        set_fetch(pc, ADDI_INST);
        check_pred(1'b0, 1'b0, pc + 32'd4);
        end_test();
    endtask

    task automatic test_bimodal();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tgt;
        begin_test("bimodal");
        pc = rand_pc(8'h10);
        tgt = rand_addr();
        if (tgt == pc + 32'h100) begin
            tgt = tgt + 32'd8;   // btb target must differ from the static one
        end
        set_fetch(pc, branch_inst(B_OFF));
        check_pred(1'b1, 1'b0, pc + 32'd4);
        repeat (2) resolve_one(pc, branch_inst(B_OFF), 1'b1, tgt);
        check_pred(1'b1, 1'b1, tgt);
        repeat (3) resolve_one(pc, branch_inst(B_OFF), 1'b0, pc + 32'd4);
        check_pred(1'b1, 1'b0, pc + 32'd4);
        end_test();
    endtask

    task automatic test_jal();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] alias_pc;
        logic [XLEN-1:0] tgt;
        begin_test("jal");
        pc = rand_pc(8'h20);
        alias_pc = pc ^ 32'h0040_0000;   // same index, tag bit 22 flipped
        tgt = rand_addr();
        set_fetch(pc, jal_inst(J_OFF));
        check_pred(1'b1, 1'b1, pc - 32'd2048);
        resolve_one(pc, jal_inst(J_OFF), 1'b1, tgt);
        check_pred(1'b1, 1'b1, tgt);
        set_fetch(alias_pc, jal_inst(J_OFF));
        check_pred(1'b1, 1'b1, alias_pc - 32'd2048);
        end_test();
    endtask

    task automatic test_return();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] addrs [3];
        begin_test("return");
        pc = rand_pc(8'h30);
        for (int k = 0; k < 3; k++) begin
            addrs[k] = rand_addr();
            push_one(addrs[k], 1'b0);
        end
        set_fetch(pc, RET_INST);
        check_pred(1'b1, 1'b1, addrs[2]);
        resolve_one(pc, RET_INST, 1'b1, addrs[2]);
        check_pred(1'b1, 1'b1, addrs[1]);
        resolve_one(pc, RET_INST, 1'b1, addrs[1]);
        resolve_one(pc, RET_INST, 1'b1, addrs[0]);
        check_pred(1'b1, 1'b0, pc + 32'd4);   // stack drained
        end_test();
    endtask

    task automatic test_push_qual();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] addrs [33];
        begin_test("push_qual");
        pc = rand_pc(8'h30);
        push_one(rand_addr(), 1'b1);
        set_fetch(pc, RET_INST);
        check_pred(1'b1, 1'b0, pc + 32'd4);
        for (int k = 0; k < 33; k++) begin
            addrs[k] = rand_addr();
        end
        addrs[32] = addrs[31] ^ 32'h0000_1000;   // dropped push must be visible
        for (int k = 0; k < 33; k++) begin
            push_one(addrs[k], 1'b0);
        end
        check_pred(1'b1, 1'b1, addrs[31]);
        end_test();
    endtask

    task automatic test_reset();
        logic [XLEN-1:0] br_pc;
        logic [XLEN-1:0] jal_pc;
        logic [XLEN-1:0] ret_pc;
        logic [XLEN-1:0] tgt;
        begin_test("reset");
        br_pc = rand_pc(8'h40);
        jal_pc = rand_pc(8'h50);
        ret_pc = rand_pc(8'h30);
        tgt = rand_addr();
        repeat (2) resolve_one(br_pc, branch_inst(B_OFF), 1'b1, tgt);
        resolve_one(jal_pc, jal_inst(J_OFF), 1'b1, tgt);
        set_fetch(br_pc, branch_inst(B_OFF));
        check_pred(1'b1, 1'b1, tgt);
        apply_reset();
        check_pred(1'b1, 1'b0, br_pc + 32'd4);
        set_fetch(jal_pc, jal_inst(J_OFF));
        check_pred(1'b1, 1'b1, jal_pc - 32'd2048);
        set_fetch(ret_pc, RET_INST);
        check_pred(1'b1, 1'b0, ret_pc + 32'd4);   // full stack emptied
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        fetch_pc = '0;
        fetch_inst = ADDI_INST;
        resolve_valid = 1'b0;
        resolve = '0;
        ras_push_valid = 1'b0;
        ras_push_addr = '0;
        stall = 1'b0;
        apply_reset();
        test_non_cf();
        test_bimodal();
        test_jal();
        test_return();
        test_push_qual();
        test_reset();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== bpu_lite.f ====
rtl/bpu_pkg.sv
rtl/cf_decode.sv
rtl/bimodal_table.sv
rtl/btb.sv
rtl/ras.sv
rtl/bpu_top.sv
sim/tb_bpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the bpu_lite testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_bpu -f bpu_lite.f -o tb_bpu_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_bpu_sim > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
exit 0
